/* dcache_miss.f */
hw/dmiss_pkg.sv
hw/miss_queue.sv
hw/load_waiter.sv
hw/line_fetch.sv
hw/dcache_miss.sv
testbench/mem_model.sv
testbench/dcache_miss_tb.sv

/* testbench/dcache_miss_tb.sv */
`timescale 1ns/1ns

module dcache_miss_tb
    import dmiss_pkg::*;
();
    localparam int MISS_ENTRIES = 4;
    localparam int WAIT_ENTRIES = 8;
    localparam int PERIOD = 10;
    localparam int unsigned SEED = 32'h2c2c_2157;
    localparam int NUM_ROWS = 5;
    localparam int MAX_OPS = 6;
    localparam int MAX_LINES = 8;

    typedef struct packed {
        logic is_st;
        addr_t addr;
        lq_tag_t tag;
        word_t data;
        logic [3:0] be;
        logic exp_full;
    } op_t;

    logic clk = 1'b0;
    logic rst;
    logic ld_valid;
    addr_t ld_addr;
    lq_tag_t ld_tag;
    logic ld_full;
    logic st_valid;
    addr_t st_addr;
    line_t st_data;
    line_mask_t st_mask;
    logic st_full;
    logic ar_valid;
    addr_t ar_addr;
    logic ar_ready;
    logic r_valid;
    word_t r_data;
    logic r_last;
    logic refill_valid;
    addr_t refill_addr;
    line_t refill_data;
    logic refill_dirty;
    logic refill_ack;
    logic resp_valid;
    lq_tag_t resp_tag;
    word_t resp_data;
    int ar_count;

    // stimulus table
    op_t ops [NUM_ROWS][MAX_OPS];
    int n_ops [NUM_ROWS];
    lq_tag_t res_tag [NUM_ROWS][MAX_OPS];
    int n_res [NUM_ROWS];
    int ack_hold [NUM_ROWS];
    int exp_refills [NUM_ROWS];
    int exp_ar [NUM_ROWS];
    string row_name [NUM_ROWS];

    // lines of the current row in allocation order
    line_addr_t exp_line [MAX_LINES];
    line_t exp_data [MAX_LINES];
    logic exp_dirty [MAX_LINES];
    int n_exp;

    addr_t got_ar [$];
    addr_t got_addr [$];
    line_t got_data [$];
    logic got_dirty [$];
    lq_tag_t got_tag [$];
    word_t got_word [$];

    int errors = 0;
    int failed_tests = 0;

    always #(PERIOD / 2) clk = ~clk;

    dcache_miss #(
        .MISS_ENTRIES (MISS_ENTRIES),
        .WAIT_ENTRIES (WAIT_ENTRIES)
    ) dut_i (
        .clk          (clk),
        .rst          (rst),
        .ld_valid     (ld_valid),
        .ld_addr      (ld_addr),
        .ld_tag       (ld_tag),
        .ld_full      (ld_full),
        .st_valid     (st_valid),
        .st_addr      (st_addr),
        .st_data      (st_data),
        .st_mask      (st_mask),
        .st_full      (st_full),
        .ar_valid     (ar_valid),
        .ar_addr      (ar_addr),
        .ar_ready     (ar_ready),
        .r_valid      (r_valid),
        .r_data       (r_data),
        .r_last       (r_last),
        .refill_valid (refill_valid),
        .refill_addr  (refill_addr),
        .refill_data  (refill_data),
        .refill_dirty (refill_dirty),
        .refill_ack   (refill_ack),
        .resp_valid   (resp_valid),
        .resp_tag     (resp_tag),
        .resp_data    (resp_data)
    );

    mem_model #(
        .SEED (SEED)
    ) mem_i (
        .clk      (clk),
        .rst      (rst),
        .ar_valid (ar_valid),
        .ar_addr  (ar_addr),
        .ar_ready (ar_ready),
        .r_valid  (r_valid),
        .r_data   (r_data),
        .r_last   (r_last),
        .ar_count (ar_count)
    );

    // transfers seen here complete at the next rising edge
    always @(negedge clk) begin
        if (!rst && ar_valid && ar_ready) begin
            got_ar.push_back(ar_addr);
        end
        if (!rst && refill_valid && refill_ack) begin
            got_addr.push_back(refill_addr);
            got_data.push_back(refill_data);
            got_dirty.push_back(refill_dirty);
        end
        if (!rst && resp_valid) begin
            got_tag.push_back(resp_tag);
            got_word.push_back(resp_data);
        end
    end

    task automatic check_value(input string name, input logic [255:0] got,
                               input logic [255:0] exp);
        assert (got === exp) else begin
            $display("Mismatch at %0t ns: %s expected %0h, got %0h", $time, name, exp, got);
            errors++;
        end
    endtask

    function automatic line_t mem_line(input line_addr_t la);
        for (int w = 0; w < LINE_WORDS; w++) begin
            mem_line[w] = ~({la, {LINE_OFS_W{1'b0}}} + addr_t'(w * WORD_BYTES));
        end
    endfunction

    function automatic int find_line(input line_addr_t la);
        find_line = -1;
        for (int k = n_exp - 1; k >= 0; k--) begin
            if (exp_line[k] == la) begin
                find_line = k;
            end
        end
    endfunction

    // memory line per line with the row's store bytes on top
    function automatic void build_expect(input int r);
        int k;
        int w;
        op_t op;
        n_exp = 0;
        for (int i = 0; i < n_ops[r]; i++) begin
            op = ops[r][i];
            if (!op.exp_full) begin
                k = find_line(op.addr[ADDR_W-1:LINE_OFS_W]);
                if (k < 0) begin
                    k = n_exp;
                    exp_line[k] = op.addr[ADDR_W-1:LINE_OFS_W];
                    exp_data[k] = mem_line(exp_line[k]);
                    exp_dirty[k] = 1'b0;
                    n_exp++;
                end
                if (op.is_st) begin
                    w = op.addr[LINE_OFS_W-1 -: WORD_SEL_W];
                    for (int b = 0; b < WORD_BYTES; b++) begin
                        if (op.be[b]) begin
                            exp_data[k][w][8*b +: 8] = op.data[8*b +: 8];
                        end
                    end
                    exp_dirty[k] = 1'b1;
                end
            end
        end
    endfunction

    function automatic word_t exp_word(input int r, input lq_tag_t tag);
        int k;
        exp_word = '0;
        for (int i = 0; i < n_ops[r]; i++) begin
            if (!ops[r][i].is_st && !ops[r][i].exp_full && ops[r][i].tag == tag) begin
                k = find_line(ops[r][i].addr[ADDR_W-1:LINE_OFS_W]);
                if (k >= 0) begin
                    exp_word = exp_data[k][ops[r][i].addr[LINE_OFS_W-1 -: WORD_SEL_W]];
                end
            end
        end
    endfunction

    task automatic set_row(input int r, input string name, input int hold,
                           input int refills, input int ars);
        row_name[r] = name;
        ack_hold[r] = hold;
        exp_refills[r] = refills;
        exp_ar[r] = ars;
        n_ops[r] = 0;
        n_res[r] = 0;
    endtask

    task automatic add_op(input int r, input logic is_st, input addr_t addr, input lq_tag_t tag,
                          input word_t data, input logic [3:0] be, input logic full);
        op_t op;
        op.is_st = is_st;
        op.addr = addr;
        op.tag = tag;
        op.data = data;
        op.be = be;
        op.exp_full = full;
        ops[r][n_ops[r]] = op;
        n_ops[r]++;
    endtask

    task automatic add_result(input int r, input lq_tag_t tag);
        res_tag[r][n_res[r]] = tag;
        n_res[r]++;
    endtask

    task automatic load_table();
        set_row(0, "single load miss", 0, 1, 1);
        add_op(0, 1'b0, 32'h0000_1008, 4'd1, '0, '0, 1'b0);
        add_result(0, 4'd1);
        set_row(1, "two loads one line", 0, 1, 1);
        add_op(1, 1'b0, 32'h0000_2004, 4'd2, '0, '0, 1'b0);
        add_op(1, 1'b0, 32'h0000_201c, 4'd3, '0, '0, 1'b0);
        add_result(1, 4'd2);
        add_result(1, 4'd3);
        set_row(2, "store then load", 0, 1, 1);
        add_op(2, 1'b1, 32'h0000_3008, 4'd0, 32'hcafe_f00d, 4'b0110, 1'b0);
        add_op(2, 1'b0, 32'h0000_3008, 4'd4, '0, '0, 1'b0);
        add_result(2, 4'd4);
        // fifth distinct line finds the queue full
        set_row(3, "queue full", 10, 4, 4);
        add_op(3, 1'b0, 32'h0000_4000, 4'd5, '0, '0, 1'b0);
        add_op(3, 1'b0, 32'h0000_4020, 4'd6, '0, '0, 1'b0);
        add_op(3, 1'b0, 32'h0000_4040, 4'd7, '0, '0, 1'b0);
        add_op(3, 1'b0, 32'h0000_4060, 4'd8, '0, '0, 1'b0);
        add_op(3, 1'b0, 32'h0000_4080, 4'd9, '0, '0, 1'b1);
        add_op(3, 1'b0, 32'h0000_4024, 4'd10, '0, '0, 1'b0);
        add_result(3, 4'd5);
        add_result(3, 4'd6);
        add_result(3, 4'd10);
        add_result(3, 4'd7);
        add_result(3, 4'd8);
        set_row(4, "refill back-pressure", 20, 3, 3);
        add_op(4, 1'b0, 32'h0000_5000, 4'd11, '0, '0, 1'b0);
        add_op(4, 1'b1, 32'h0000_5044, 4'd0, 32'h1234_5678, 4'b1001, 1'b0);
        add_op(4, 1'b0, 32'h0000_5044, 4'd12, '0, '0, 1'b0);
        add_op(4, 1'b0, 32'h0000_5080, 4'd13, '0, '0, 1'b0);
        add_result(4, 4'd11);
        add_result(4, 4'd12);
        add_result(4, 4'd13);
    endtask

    task automatic issue_ops(input int r);
        op_t op;
        int w;
        for (int i = 0; i < n_ops[r]; i++) begin
            op = ops[r][i];
            w = op.addr[LINE_OFS_W-1 -: WORD_SEL_W];
            if (op.is_st) begin
                st_valid = 1'b1;
                st_addr = {op.addr[ADDR_W-1:LINE_OFS_W], {LINE_OFS_W{1'b0}}};
                st_data = '0;
                st_data[w] = op.data;
                st_mask = '0;
                st_mask[w*WORD_BYTES +: WORD_BYTES] = op.be;
            end else begin
                ld_valid = 1'b1;
                ld_addr = op.addr;
                ld_tag = op.tag;
            end
            @(posedge clk);
            #1;
            ld_valid = 1'b0;
            st_valid = 1'b0;
            if (op.is_st) begin
                check_value("st_full", st_full, op.exp_full);
            end else begin
                check_value("ld_full", ld_full, op.exp_full);
            end
        end
    endtask

    // refill outputs must not move while the cache holds off
    task automatic hold_refill(input int hold);
        addr_t addr0;
        line_t data0;
        logic dirty0;
        if (hold > 0) begin
            while (!refill_valid) begin
                @(posedge clk);
                #1;
            end
            addr0 = refill_addr;
            data0 = refill_data;
            dirty0 = refill_dirty;
            repeat (hold) begin
                @(posedge clk);
                #1;
                check_value("refill_valid", refill_valid, 1'b1);
                check_value("refill_addr", refill_addr, addr0);
                check_value("refill_data", refill_data, data0);
                check_value("refill_dirty", refill_dirty, dirty0);
            end
        end
        refill_ack = 1'b1;
    endtask

    task automatic run_row(input int r);
        int ar_start;
        got_ar.delete();
        got_addr.delete();
        got_data.delete();
        got_dirty.delete();
        got_tag.delete();
        got_word.delete();
        ar_start = ar_count;
        build_expect(r);
        issue_ops(r);
        hold_refill(ack_hold[r]);
        while (got_tag.size() < n_res[r] || got_addr.size() < exp_refills[r]) begin
            @(posedge clk);
            #1;
        end
        // catch stray outputs and let the entries drain
        repeat (6) @(posedge clk);
        #1;
        refill_ack = 1'b0;
        check_value("address handshakes", ar_count - ar_start, exp_ar[r]);
        check_value("refill count", got_addr.size(), exp_refills[r]);
        check_value("result count", got_tag.size(), n_res[r]);
        for (int j = 0; j < got_ar.size() && j < n_exp; j++) begin
            check_value("ar_addr", got_ar[j], {exp_line[j], {LINE_OFS_W{1'b0}}});
        end
        for (int j = 0; j < got_addr.size() && j < n_exp; j++) begin
            check_value("refill_addr", got_addr[j], {exp_line[j], {LINE_OFS_W{1'b0}}});
            check_value("refill_data", got_data[j], exp_data[j]);
            check_value("refill_dirty", got_dirty[j], exp_dirty[j]);
        end
        for (int j = 0; j < got_tag.size() && j < n_res[r]; j++) begin
            check_value("resp_tag", got_tag[j], res_tag[r][j]);
            check_value("resp_data", got_word[j], exp_word(r, res_tag[r][j]));
        end
    endtask

    // reset lands while a refill is pending and a load still waits
    task automatic check_reset();
        ld_valid = 1'b1;
        ld_addr = 32'h0000_6010;
        ld_tag = 4'd14;
        @(posedge clk);
        #1;
        ld_valid = 1'b0;
        while (!refill_valid) begin
            @(posedge clk);
            #1;
        end
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        check_value("ld_full", ld_full, 1'b0);
        check_value("st_full", st_full, 1'b0);
        check_value("ar_valid", ar_valid, 1'b0);
        check_value("refill_valid", refill_valid, 1'b0);
        check_value("resp_valid", resp_valid, 1'b0);
    endtask

    task automatic report_test(input int num, input string name, input int errs);
        if (errs == 0) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errs);
            failed_tests++;
        end
    endtask

    initial begin
        int start_errors;
        rst = 1'b1;
        ld_valid = 1'b0;
        ld_addr = '0;
        ld_tag = '0;
        st_valid = 1'b0;
        st_addr = '0;
        st_data = '0;
        st_mask = '0;
        refill_ack = 1'b0;
        load_table();
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            start_errors = errors;
            run_row(r);
            report_test(r + 1, row_name[r], errors - start_errors);
        end
        start_errors = errors;
        check_reset();
        report_test(NUM_ROWS + 1, "after reset", errors - start_errors);
        $display("%0d tests, %0d passed, %0d failed, %0d check errors", NUM_ROWS + 1,
                 NUM_ROWS + 1 - failed_tests, failed_tests, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // 400 cycles per row
    initial begin
        #(NUM_ROWS * 400 * PERIOD);
        $display("timeout: run still busy after %0d cycles", NUM_ROWS * 400);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* testbench/mem_model.sv */
`timescale 1ns/1ns

module mem_model
    import dmiss_pkg::*;
#(
    parameter int unsigned SEED = 0
) (
    input  logic  clk,
    input  logic  rst,

    input  logic  ar_valid,
    input  addr_t ar_addr,
    output logic  ar_ready,

    output logic  r_valid,
    output word_t r_data,
    output logic  r_last,

    output int    ar_count
);
    addr_t base;
    int unsigned seed_state;

    // one burst at a time, each word reads back as its own address inverted
    initial begin
        seed_state = SEED;
        seed_state = $urandom(seed_state);
        ar_ready = 1'b0;
        r_valid = 1'b0;
        r_data = '0;
        r_last = 1'b0;
        ar_count = 0;
        forever begin
            @(posedge clk);
            #1;
            if (ar_valid && !rst) begin
                // random stall on the address channel
                repeat ($urandom_range(2, 0)) begin
                    @(posedge clk);
                    #1;
                end
                ar_ready = 1'b1;
                base = ar_addr;
                @(posedge clk);
                ar_count++;
                #1;
                ar_ready = 1'b0;
                for (int beat = 0; beat < LINE_WORDS; beat++) begin
                    // gap before each beat
                    repeat ($urandom_range(1, 0)) begin
                        @(posedge clk);
                        #1;
                    end
                    r_valid = 1'b1;
                    r_data = ~(base + addr_t'(beat * WORD_BYTES));
                    r_last = (beat == LINE_WORDS - 1);
                    @(posedge clk);
                    #1;
                    r_valid = 1'b0;
                    r_last = 1'b0;
                end
            end
        end
    end

endmodule

/* hw/dcache_miss.sv */
`timescale 1ns/1ns

module dcache_miss
    import dmiss_pkg::*;
#(
    parameter int MISS_ENTRIES = 4,
    parameter int WAIT_ENTRIES = 4
) (
    input  logic       clk,
    input  logic       rst,

    input  logic       ld_valid,
    input  addr_t      ld_addr,
    input  lq_tag_t    ld_tag,
    output logic       ld_full,

    input  logic       st_valid,
    input  addr_t      st_addr,
    input  line_t      st_data,
    input  line_mask_t st_mask,
    output logic       st_full,

    output logic       ar_valid,
    output addr_t      ar_addr,
    input  logic       ar_ready,
    input  logic       r_valid,
    input  word_t      r_data,
    input  logic       r_last,

    output logic       refill_valid,
    output addr_t      refill_addr,
    output line_t      refill_data,
    output logic       refill_dirty,
    input  logic       refill_ack,

    output logic       resp_valid,
    output lq_tag_t    resp_tag,
    output word_t      resp_data
);
    localparam int IDX_W = $clog2(MISS_ENTRIES);

    logic ld_accept;
    logic [IDX_W-1:0] alloc_idx;
    logic wait_free;

    logic fetch_start;
    line_addr_t fetch_addr;
    line_t head_data;
    line_mask_t head_mask;
    logic fill_beat_last;
    logic fill_done;
    line_t fill_line;

    logic wake_valid;
    logic [IDX_W-1:0] wake_idx;
    line_t wake_line;
    logic wake_done;

    miss_queue #(
        .MISS_ENTRIES (MISS_ENTRIES)
    ) miss_queue_i (
        .clk            (clk),
        .rst            (rst),
        .ld_valid       (ld_valid),
        .ld_addr        (ld_addr),
        .ld_accept      (ld_accept),
        .ld_full        (ld_full),
        .alloc_idx      (alloc_idx),
        .st_valid       (st_valid),
        .st_addr        (st_addr),
        .st_data        (st_data),
        .st_mask        (st_mask),
        .st_full        (st_full),
        .wait_free      (wait_free),
        .fetch_start    (fetch_start),
        .fetch_addr     (fetch_addr),
        .head_data      (head_data),
        .head_mask      (head_mask),
        .fill_beat_last (fill_beat_last),
        .fill_done      (fill_done),
        .fill_line      (fill_line),
        .refill_valid   (refill_valid),
        .refill_addr    (refill_addr),
        .refill_data    (refill_data),
        .refill_dirty   (refill_dirty),
        .refill_ack     (refill_ack),
        .wake_valid     (wake_valid),
        .wake_idx       (wake_idx),
        .wake_line      (wake_line),
        .wake_done      (wake_done)
    );

    load_waiter #(
        .MISS_ENTRIES (MISS_ENTRIES),
        .WAIT_ENTRIES (WAIT_ENTRIES)
    ) load_waiter_i (
        .clk        (clk),
        .rst        (rst),
        .ld_accept  (ld_accept),
        .ld_addr    (ld_addr),
        .ld_tag     (ld_tag),
        .alloc_idx  (alloc_idx),
        .wait_free  (wait_free),
        .wake_valid (wake_valid),
        .wake_idx   (wake_idx),
        .wake_line  (wake_line),
        .wake_done  (wake_done),
        .resp_valid (resp_valid),
        .resp_tag   (resp_tag),
        .resp_data  (resp_data)
    );

    line_fetch line_fetch_i (
        .clk            (clk),
        .rst            (rst),
        .fetch_start    (fetch_start),
        .fetch_addr     (fetch_addr),
        .head_data      (head_data),
        .head_mask      (head_mask),
        .ar_valid       (ar_valid),
        .ar_addr        (ar_addr),
        .ar_ready       (ar_ready),
        .r_valid        (r_valid),
        .r_data         (r_data),
        .r_last         (r_last),
        .fill_beat_last (fill_beat_last),
        .fill_done      (fill_done),
        .fill_line      (fill_line)
    );

endmodule

/* hw/line_fetch.sv */
`timescale 1ns/1ns

module line_fetch
    import dmiss_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    input  logic       fetch_start,
    input  line_addr_t fetch_addr,
    input  line_t      head_data,
    input  line_mask_t head_mask,

    output logic       ar_valid,
    output addr_t      ar_addr,
    input  logic       ar_ready,

    input  logic       r_valid,
    input  word_t      r_data,
    input  logic       r_last,

    output logic       fill_beat_last,
    output logic       fill_done,
    output line_t      fill_line
);
    // burst accepted, beats still due
    logic busy;
    logic [WORD_SEL_W-1:0] beat_cnt;
    line_t beat_buf;
    line_t hold_data;
    line_mask_t hold_mask;

    assign fill_beat_last = r_valid & r_last;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ar_valid <= 1'b0;
            busy <= 1'b0;
            beat_cnt <= '0;
            fill_done <= 1'b0;
        end else begin
            fill_done <= fill_beat_last;
            if (fetch_start) begin
                ar_valid <= 1'b1;
            end
            if (ar_valid && ar_ready) begin
                ar_valid <= 1'b0;
                busy <= 1'b1;
            end
            if (r_valid) begin
                beat_cnt <= beat_cnt + 1'b1;
                if (r_last) begin
                    busy <= 1'b0;
                    beat_cnt <= '0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_start) begin
            ar_addr <= {fetch_addr, {LINE_OFS_W{1'b0}}};
        end
        if (r_valid) begin
            beat_buf[beat_cnt] <= r_data;
        end
        // stores are held off from here until the merged line is written
        if (fill_beat_last) begin
            hold_data <= head_data;
            hold_mask <= head_mask;
        end
    end

    // store bytes over memory bytes
    always_comb begin
        fill_line = beat_buf;
        for (int w = 0; w < LINE_WORDS; w++) begin
            for (int k = 0; k < WORD_BYTES; k++) begin
                if (hold_mask[w*WORD_BYTES+k]) begin
                    fill_line[w][8*k +: 8] = hold_data[w][8*k +: 8];
                end
            end
        end
    end

    no_stray_beat: assert property (@(posedge clk) disable iff (rst)
        r_valid |-> busy);

endmodule

/* hw/load_waiter.sv */
`timescale 1ns/1ns

module load_waiter
    import dmiss_pkg::*;
#(
    parameter int MISS_ENTRIES = 4,
    parameter int WAIT_ENTRIES = 4
) (
    input  logic                            clk,
    input  logic                            rst,

    input  logic                            ld_accept,
    input  addr_t                           ld_addr,
    input  lq_tag_t                         ld_tag,
    input  logic [$clog2(MISS_ENTRIES)-1:0] alloc_idx,
    output logic                            wait_free,

    input  logic                            wake_valid,
    input  logic [$clog2(MISS_ENTRIES)-1:0] wake_idx,
    input  line_t                           wake_line,
    output logic                            wake_done,

    output logic                            resp_valid,
    output lq_tag_t                         resp_tag,
    output word_t                           resp_data
);
    localparam int IDX_W = $clog2(MISS_ENTRIES);
    localparam int SLOT_W = $clog2(WAIT_ENTRIES);

    logic [WAIT_ENTRIES-1:0] w_valid;
    lq_tag_t w_tag [WAIT_ENTRIES];
    logic [IDX_W-1:0] w_idx [WAIT_ENTRIES];
    logic [WORD_SEL_W-1:0] w_ofs [WAIT_ENTRIES];

    logic [SLOT_W-1:0] free_slot;
    logic [SLOT_W-1:0] match_slot;
    logic match_any;
    logic serve;

    // lowest free slot and lowest waiter on the woken entry
    always_comb begin
        free_slot = '0;
        match_slot = '0;
        match_any = 1'b0;
        for (int i = WAIT_ENTRIES - 1; i >= 0; i--) begin
            if (!w_valid[i]) begin
                free_slot = SLOT_W'(i);
            end
            if (w_valid[i] && (w_idx[i] == wake_idx)) begin
                match_slot = SLOT_W'(i);
                match_any = 1'b1;
            end
        end
    end

    assign wait_free = ~&w_valid;
    assign serve = wake_valid & match_any;

    // nobody left on this entry
    assign wake_done = wake_valid & ~match_any;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            w_valid <= '0;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= serve;
            if (ld_accept) begin
                w_valid[free_slot] <= 1'b1;
            end
            if (serve) begin
                w_valid[match_slot] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ld_accept) begin
            w_tag[free_slot] <= ld_tag;
            w_idx[free_slot] <= alloc_idx;
            w_ofs[free_slot] <= ld_addr[LINE_OFS_W-1 -: WORD_SEL_W];
        end
        if (serve) begin
            resp_tag <= w_tag[match_slot];
            resp_data <= wake_line[w_ofs[match_slot]];
        end
    end

    // a load is only handed over while a slot is free
    accept_has_slot: assert property (@(posedge clk) disable iff (rst)
        ld_accept |-> wait_free);

endmodule

/* hw/miss_queue.sv */
`timescale 1ns/1ns

module miss_queue
    import dmiss_pkg::*;
#(
    parameter int MISS_ENTRIES = 4
) (
    input  logic                            clk,
    input  logic                            rst,

    input  logic                            ld_valid,
    input  addr_t                           ld_addr,
    output logic                            ld_accept,
    output logic                            ld_full,
    output logic [$clog2(MISS_ENTRIES)-1:0] alloc_idx,

    input  logic                            st_valid,
    input  addr_t                           st_addr,
    input  line_t                           st_data,
    input  line_mask_t                      st_mask,
    output logic                            st_full,

    input  logic                            wait_free,

    output logic                            fetch_start,
    output line_addr_t                      fetch_addr,
    output line_t                           head_data,
    output line_mask_t                      head_mask,
    input  logic                            fill_beat_last,
    input  logic                            fill_done,
    input  line_t                           fill_line,

    output logic                            refill_valid,
    output addr_t                           refill_addr,
    output line_t                           refill_data,
    output logic                            refill_dirty,
    input  logic                            refill_ack,

    output logic                            wake_valid,
    output logic [$clog2(MISS_ENTRIES)-1:0] wake_idx,
    output line_t                           wake_line,
    input  logic                            wake_done
);
    localparam int IDX_W = $clog2(MISS_ENTRIES);
    localparam int CNT_W = IDX_W + 1;

    line_addr_t ent_addr [MISS_ENTRIES];
    line_t ent_data [MISS_ENTRIES];
    line_mask_t ent_mask [MISS_ENTRIES];
    logic [MISS_ENTRIES-1:0] ent_valid;
    logic [MISS_ENTRIES-1:0] ent_ready;
    logic [MISS_ENTRIES-1:0] ent_refilled;

    logic [IDX_W-1:0] head;
    logic [IDX_W-1:0] tail;
    logic [IDX_W-1:0] wake_ptr;
    logic [CNT_W-1:0] free_cnt;
    logic fetch_busy;

    line_addr_t ld_line;
    line_addr_t st_line;
    logic refill_fire;
    logic [MISS_ENTRIES-1:0] live;
    logic [MISS_ENTRIES-1:0] ld_hit;
    logic [MISS_ENTRIES-1:0] st_hit;
    logic [IDX_W-1:0] ld_hit_idx;
    logic [IDX_W-1:0] st_hit_idx;
    logic [IDX_W-1:0] st_idx;
    logic ld_new;
    logic st_new;
    logic st_same;
    logic st_block;
    logic st_accept;
    line_t merge_data;
    line_mask_t merge_mask;

    assign ld_line = ld_addr[ADDR_W-1:LINE_OFS_W];
    assign st_line = st_addr[ADDR_W-1:LINE_OFS_W];
    assign refill_fire = refill_valid & refill_ack;

    // line compare, the head leaving this cycle no longer counts
    always_comb begin
        ld_hit_idx = '0;
        st_hit_idx = '0;
        for (int i = MISS_ENTRIES - 1; i >= 0; i--) begin
            live[i] = ent_valid[i] & ~(refill_fire & (head == IDX_W'(i)));
            ld_hit[i] = live[i] & (ent_addr[i] == ld_line);
            st_hit[i] = live[i] & (ent_addr[i] == st_line);
            if (ld_hit[i]) begin
                ld_hit_idx = IDX_W'(i);
            end
            if (st_hit[i]) begin
                st_hit_idx = IDX_W'(i);
            end
        end
    end

    assign ld_accept = ld_valid & wait_free & ((|ld_hit) | (free_cnt != '0));
    assign ld_new = ld_accept & ~(|ld_hit);
    assign alloc_idx = (|ld_hit) ? ld_hit_idx : tail;

    // beat buffer latches head bytes on the last beat, merged line lands next cycle
    assign st_block = fill_beat_last | fill_done;
    assign st_same = ld_new & (st_line == ld_line);
    assign st_accept = st_valid & ~st_block
                     & ((|st_hit) | st_same | (free_cnt > CNT_W'(ld_new)));
    assign st_new = st_accept & ~(|st_hit) & ~st_same;
    assign st_idx = (|st_hit) ? st_hit_idx :
                    st_same   ? tail : tail + IDX_W'(ld_new);

    always_comb begin
        merge_data = ent_data[st_idx];
        merge_mask = (|st_hit) ? (ent_mask[st_idx] | st_mask) : st_mask;
        for (int w = 0; w < LINE_WORDS; w++) begin
            for (int k = 0; k < WORD_BYTES; k++) begin
                if (st_mask[w*WORD_BYTES+k]) begin
                    merge_data[w][8*k +: 8] = st_data[w][8*k +: 8];
                end
            end
        end
    end

    assign fetch_start = ent_valid[head] & ~ent_ready[head] & ~fetch_busy;
    assign fetch_addr = ent_addr[head];
    assign head_data = ent_data[head];
    assign head_mask = ent_mask[head];

    assign refill_valid = ent_valid[head] & ent_ready[head];
    assign refill_addr = {ent_addr[head], {LINE_OFS_W{1'b0}}};
    assign refill_data = ent_data[head];
    assign refill_dirty = |ent_mask[head];

    assign wake_valid = ent_refilled[wake_ptr];
    assign wake_idx = wake_ptr;
    assign wake_line = ent_data[wake_ptr];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ent_valid <= '0;
            ent_ready <= '0;
            ent_refilled <= '0;
            head <= '0;
            tail <= '0;
            wake_ptr <= '0;
            free_cnt <= CNT_W'(MISS_ENTRIES);
            fetch_busy <= 1'b0;
            ld_full <= 1'b0;
            st_full <= 1'b0;
        end else begin
            ld_full <= ld_valid & ~ld_accept;
            st_full <= st_valid & ~st_accept;
            if (ld_new) begin
                ent_valid[tail] <= 1'b1;
                ent_ready[tail] <= 1'b0;
            end
            if (st_new) begin
                ent_valid[st_idx] <= 1'b1;
                ent_ready[st_idx] <= 1'b0;
            end
            tail <= tail + IDX_W'(ld_new) + IDX_W'(st_new);
            if (fetch_start) begin
                fetch_busy <= 1'b1;
            end
            if (fill_done) begin
                fetch_busy <= 1'b0;
                ent_ready[head] <= 1'b1;
            end
            if (refill_fire) begin
                ent_valid[head] <= 1'b0;
                ent_ready[head] <= 1'b0;
                ent_refilled[head] <= 1'b1;
                head <= head + 1'b1;
            end
            // slot comes back only once all its loads are served
            if (wake_done) begin
                ent_refilled[wake_ptr] <= 1'b0;
                wake_ptr <= wake_ptr + 1'b1;
            end
            free_cnt <= free_cnt - CNT_W'(ld_new) - CNT_W'(st_new) + CNT_W'(wake_done);
        end
    end

    always_ff @(posedge clk) begin
        if (ld_new) begin
            ent_addr[tail] <= ld_line;
            ent_mask[tail] <= '0;
        end
        if (st_new) begin
            ent_addr[st_idx] <= st_line;
        end
        if (st_accept) begin
            ent_data[st_idx] <= merge_data;
            ent_mask[st_idx] <= merge_mask;
        end
        if (fill_done) begin
            ent_data[head] <= fill_line;
        end
    end

    free_cnt_bound: assert property (@(posedge clk) disable iff (rst)
        free_cnt <= CNT_W'(MISS_ENTRIES));

    // refill only from a live head whose burst has finished
    refill_head_live: assert property (@(posedge clk) disable iff (rst)
        refill_valid |-> ent_valid[head] && !fetch_busy);

endmodule

/* hw/dmiss_pkg.sv */
package dmiss_pkg;

    // address and data widths
    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;
    localparam int WORD_BYTES = 4;

    // line geometry, one burst fills one line
    localparam int LINE_WORDS = 8;
    localparam int LINE_OFS_W = 5;
    localparam int WORD_SEL_W = $clog2(LINE_WORDS);

    typedef logic [ADDR_W-1:0] addr_t;

    // line number, byte offset stripped
    typedef logic [ADDR_W-LINE_OFS_W-1:0] line_addr_t;

    typedef logic [WORD_W-1:0] word_t;

    // word 0 sits in the low bits
    typedef word_t [LINE_WORDS-1:0] line_t;

    // one enable per byte, bit w*WORD_BYTES+k is byte k of word w
    typedef logic [LINE_WORDS*WORD_BYTES-1:0] line_mask_t;

    typedef logic [3:0] lq_tag_t;

endpackage
